//--- source/fetch_pkg.sv
package fetch_pkg;

    // one 32-bit instruction per 16-bit word address
    typedef logic [15:0] addr_t;
    typedef logic [31:0] instr_t;

    // opcode field sits in instr[31:28]
    typedef enum logic [3:0] {
        op_alu     = 4'h0,
        op_load    = 4'h1,
        op_br_cond = 4'h2,  // conditional branch
        op_jump    = 4'h3   // unconditional, always taken
    } opcode_e;

    // any encoding not listed above falls back to alu behavior

    // queue entry toward dispatch, 66 bits total
    typedef struct packed {
        instr_t instruction;  // [65:34]
        addr_t  pc;           // [33:18]
        logic   is_cond_br;   // [17]
        logic   pred_taken;   // [16]
        addr_t  pred_target;  // [15:0]
    } fetch_entry_t;

    localparam int unsigned QUEUE_DEPTH = 8;

    // first fetch address after reset
    localparam addr_t RESET_PC = 16'h0000;

endpackage

//--- source/icache_pkg.sv
package icache_pkg;

    // direct mapped, 8 sets of two-instruction blocks
    localparam int unsigned NUM_SETS        = 8;
    localparam int unsigned WORDS_PER_BLOCK = 2;
    localparam int unsigned BLOCK_BITS      = 64;

    // pc[0] word select, pc[3:1] index, pc[15:4] tag
    localparam int unsigned INDEX_BITS = 3;
    localparam int unsigned TAG_BITS   = 12;

    // four-phase refill engine
    typedef enum logic [1:0] {
        idle,           // no refill in flight
        req_wait_ack,   // mem_req high, waiting for ack
        drop_wait_ack   // block written, waiting for ack to fall
    } refill_state_e;

endpackage

//--- source/fetch_lookup_if.sv
`timescale 1ns/100ps

// one lookup per cycle, fully combinational from the pc register
interface fetch_lookup_if;
    import fetch_pkg::*;

    addr_t  pc;           // from pc_gen
    logic   hit;          // from icache
    instr_t instr;        // selected word of the block
    logic   is_cond_br;   // predecode results
    logic   pred_taken;
    addr_t  pred_target;

    modport pc_side (output pc, input hit, input pred_target);

    modport cache_side (input pc, output hit, output instr);

    modport predict_side (
        input  pc,
        input  instr,
        output is_cond_br,
        output pred_taken,
        output pred_target
    );

endinterface

//--- source/pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t recovery_pc,
    input  logic             recovery_pc_valid,
    input  logic             enq_ready,
    fetch_lookup_if.pc_side  lookup
);
    import fetch_pkg::*;

    addr_t pc_q;
    addr_t pc_next;
    logic  advance;

    // move on only when the word was found and the queue took it
    assign advance = lookup.hit && enq_ready;

    always_comb begin
        if (recovery_pc_valid) begin
            pc_next = recovery_pc;          // branch recovery wins
        end else if (advance) begin
            pc_next = lookup.pred_target;   // static prediction
        end else begin
            pc_next = pc_q;                 // miss or queue full
        end
    end

    // written every edge, the mux feeds back the held value
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign lookup.pc = pc_q;

endmodule

//--- source/icache.sv
`timescale 1ns/100ps

module icache (
    input  logic                              clk,
    input  logic                              rst,
    fetch_lookup_if.cache_side                lookup,
    output logic                              mem_req,
    output fetch_pkg::addr_t                  mem_addr,
    input  logic                              mem_ack,
    input  logic [icache_pkg::BLOCK_BITS-1:0] mem_data
);
    import fetch_pkg::*;
    import icache_pkg::*;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef instr_t [WORDS_PER_BLOCK-1:0] block_t;  // word 0 in the low half

    // tag and data arrays
    logic [NUM_SETS-1:0] valid_q;
    tag_t                tag_q  [NUM_SETS];
    block_t              data_q [NUM_SETS];

    // lookup side
    logic [INDEX_BITS-1:0] index;
    tag_t                  tag;
    block_t                block;

    // refill side
    refill_state_e         state_q;
    addr_t                 refill_addr_q;
    logic [INDEX_BITS-1:0] refill_index;
    tag_t                  refill_tag;
    logic                  start_refill;
    logic                  fill_block;

    assign index = lookup.pc[1 +: INDEX_BITS];
    assign tag   = lookup.pc[$bits(addr_t)-1 -: TAG_BITS];
    assign block = data_q[index];

    assign lookup.hit   = valid_q[index] && (tag_q[index] == tag);
    assign lookup.instr = block[lookup.pc[0]];  // word select by pc bit 0

    // latched block address keeps the refill stable across recovery
    assign refill_index = refill_addr_q[1 +: INDEX_BITS];
    assign refill_tag   = refill_addr_q[$bits(addr_t)-1 -: TAG_BITS];

    assign start_refill = (state_q == idle) && !lookup.hit;
    assign fill_block   = (state_q == req_wait_ack) && mem_ack;  // first edge ack seen

    // control state of the four-phase handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
            valid_q <= '0;   // cold cache
        end else begin
            case (state_q)
                idle: begin
                    if (start_refill) begin
                        state_q <= req_wait_ack;
                    end
                end
                req_wait_ack: begin
                    if (mem_ack) begin
                        state_q               <= drop_wait_ack;
                        valid_q[refill_index] <= 1'b1;
                    end
                end
                drop_wait_ack: begin
                    // memory must release ack before the next request
                    if (!mem_ack) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // block address, tags and data
    always_ff @(posedge clk) begin
        if (start_refill) begin
            refill_addr_q <= {lookup.pc[$bits(addr_t)-1:1], 1'b0};  // block aligned
        end
        if (fill_block) begin
            tag_q[refill_index]  <= refill_tag;
            data_q[refill_index] <= mem_data;
        end
    end

    assign mem_req  = (state_q == req_wait_ack);  // drops right after the fill edge
    assign mem_addr = refill_addr_q;

endmodule

//--- source/next_pc_predict.sv
`timescale 1ns/100ps

module next_pc_predict (
    fetch_lookup_if.predict_side lookup
);
    import fetch_pkg::*;

    opcode_e opcode;
    addr_t   offset;
    logic    backward;
    addr_t   seq_pc;
    addr_t   br_target;

    assign opcode = opcode_e'(lookup.instr[31:28]);

    // 16-bit offset already spans the address width, so sign extension is a no-op
    assign offset    = lookup.instr[15:0];
    assign backward  = offset[$bits(addr_t)-1];
    assign seq_pc    = lookup.pc + addr_t'(1);
    assign br_target = lookup.pc + offset;  // wraps in the 64K word space

    always_comb begin
        lookup.is_cond_br  = 1'b0;
        lookup.pred_taken  = 1'b0;
        lookup.pred_target = seq_pc;
        case (opcode)
            op_jump: begin
                lookup.pred_taken  = 1'b1;    // jumps always redirect
                lookup.pred_target = br_target;
            end
            op_br_cond: begin
                lookup.is_cond_br = 1'b1;
                // backward taken, forward not taken
                if (backward) begin
                    lookup.pred_taken  = 1'b1;
                    lookup.pred_target = br_target;
                end
            end
            default: ;  // alu, load and unknown codes keep seq_pc
        endcase
    end

endmodule

//--- source/instr_queue.sv
`timescale 1ns/100ps

module instr_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    enq_valid,
    output logic                    enq_ready,
    input  fetch_pkg::fetch_entry_t enq_data,
    output logic                    deq_valid,
    input  logic                    deq_ready,
    output fetch_pkg::fetch_entry_t deq_data
);
    import fetch_pkg::*;

    typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(QUEUE_DEPTH):0]   count_t;  // one extra bit for full

    fetch_entry_t entries [QUEUE_DEPTH];
    ptr_t         rd_ptr;
    ptr_t         wr_ptr;
    count_t       count;
    logic         do_enq;
    logic         do_deq;

    assign enq_ready = (count != count_t'(QUEUE_DEPTH));
    assign deq_valid = (count != '0) && !flush;   // hidden in the flush cycle
    assign deq_data  = entries[rd_ptr];

    assign do_enq = enq_valid && enq_ready && !flush;  // flush drops the incoming word
    assign do_deq = deq_valid && deq_ready;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;  // power of two depth wraps by itself
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_enq) begin
            entries[wr_ptr] <= enq_data;
        end
    end

endmodule

//--- source/ifu_top.sv
`timescale 1ns/100ps

module ifu_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] recovery_pc,
    input  logic        recovery_pc_valid,
    output logic        mem_req,
    output logic [15:0] mem_addr,
    input  logic        mem_ack,
    input  logic [63:0] mem_data,
    input  logic        dispatch_ready,
    output logic        instr_valid,
    output logic [65:0] instr_to_dispatch
);
    import fetch_pkg::*;

    fetch_lookup_if lookup ();

    fetch_entry_t enq_entry;
    fetch_entry_t deq_entry;
    logic         enq_ready;

    pc_gen i_pc_gen (
        .clk               (clk),
        .rst               (rst),
        .recovery_pc       (recovery_pc),
        .recovery_pc_valid (recovery_pc_valid),
        .enq_ready         (enq_ready),         // queue back-pressure holds the pc
        .lookup            (lookup.pc_side)
    );

    icache i_icache (
        .clk      (clk),
        .rst      (rst),
        .lookup   (lookup.cache_side),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

    next_pc_predict i_next_pc_predict (
        .lookup (lookup.predict_side)
    );

    // entry for the word looked up this cycle
    assign enq_entry.instruction = lookup.instr;
    assign enq_entry.pc          = lookup.pc;
    assign enq_entry.is_cond_br  = lookup.is_cond_br;
    assign enq_entry.pred_taken  = lookup.pred_taken;
    assign enq_entry.pred_target = lookup.pred_target;

    instr_queue i_instr_queue (
        .clk       (clk),
        .rst       (rst),
        .flush     (recovery_pc_valid),  // recovery squashes queued work
        .enq_valid (lookup.hit),
        .enq_ready (enq_ready),
        .enq_data  (enq_entry),
        .deq_valid (instr_valid),
        .deq_ready (dispatch_ready),
        .deq_data  (deq_entry)
    );

    assign instr_to_dispatch = deq_entry;

endmodule

//--- verification/ifu_checker.sv
`timescale 1ns/100ps

module ifu_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [2:0]              test_id,
    input  logic                    test_end,
    input  logic                    instr_valid,
    input  logic                    dispatch_ready,
    input  fetch_pkg::fetch_entry_t entry,
    input  fetch_pkg::instr_t       image_word,   // program image at entry.pc
    input  fetch_pkg::addr_t        recovery_pc,
    input  logic                    recovery_pc_valid,
    input  logic                    mem_req,
    input  fetch_pkg::addr_t        mem_addr,
    input  logic                    mem_ack,
    output int                      entry_count,
    output int                      error_count
);
    import fetch_pkg::*;

    typedef struct packed {
        logic  is_cond_br;
        logic  pred_taken;
        addr_t pred_target;
    } pred_t;

    addr_t exp_pc;        // pc the next dequeued entry must carry
    pred_t exp_pred;
    int    reset_edges;
    int    test_entries;
    int    test_errors;
    logic  after_reset;   // first edge with rst low
    logic  prev_req;
    addr_t prev_addr;
    logic  ack_seen;      // ack observed during the current request

    // static rule: jumps taken, conditional branches taken only backward
    function automatic pred_t expected_next_pc(addr_t pc, instr_t instr);
        pred_t p;
        addr_t offset;
        offset        = instr[15:0];
        p.is_cond_br  = (instr[31:28] == op_br_cond);
        p.pred_taken  = (instr[31:28] == op_jump) || (p.is_cond_br && offset[15]);
        p.pred_target = p.pred_taken ? pc + offset : pc + 16'd1;
        return p;
    endfunction

    function automatic string test_name(logic [2:0] id);
        case (id)
            3'd1:    return "reset_state";
            3'd2:    return "cold_stream";
            3'd3:    return "back_pressure";
            3'd4:    return "recovery";
            default: return "no_test";
        endcase
    endfunction

    task automatic compare(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %0s: %0s expected %h actual %h",
                     test_name(test_id), what, expected, actual);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic flag_error(string msg);
        $display("[ERROR] %0s: %0s", test_name(test_id), msg);
        test_errors++;
        error_count++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            // first edge only loads the reset values
            if (reset_edges > 0 && (instr_valid !== 1'b0 || mem_req !== 1'b0)) begin
                flag_error("instr_valid or mem_req not low during reset");
            end
            reset_edges++;
            exp_pc      = RESET_PC;
            after_reset = 1'b1;
            prev_req    = 1'b0;
            ack_seen    = 1'b0;
        end else begin
            if (after_reset && (instr_valid !== 1'b0 || mem_req !== 1'b0)) begin
                flag_error("instr_valid or mem_req not low right after reset");
            end
            after_reset = 1'b0;

            if (recovery_pc_valid) begin
                if (instr_valid !== 1'b0) begin
                    flag_error("instr_valid high in a recovery cycle");
                end
                exp_pc = recovery_pc;   // stream restarts here
            end else if (instr_valid && dispatch_ready) begin
                exp_pred = expected_next_pc(exp_pc, image_word);
                compare("pc", exp_pc, entry.pc);
                compare("instruction", image_word, entry.instruction);
                compare("is_cond_br", exp_pred.is_cond_br, entry.is_cond_br);
                compare("pred_taken", exp_pred.pred_taken, entry.pred_taken);
                compare("pred_target", exp_pred.pred_target, entry.pred_target);
                exp_pc = exp_pred.pred_target;   // next pc from the model, not the dut
                entry_count++;
                test_entries++;
            end

            // four-phase refill handshake
            if (mem_req && mem_addr[0] !== 1'b0) begin
                flag_error("mem_addr not block aligned");
            end
            if (mem_req && !prev_req && mem_ack) begin
                flag_error("mem_req rose while mem_ack still high");
            end
            if (mem_req && prev_req && !ack_seen && mem_addr !== prev_addr) begin
                flag_error("mem_addr changed before mem_ack");
            end
            if (!mem_req && prev_req && !ack_seen) begin
                flag_error("mem_req fell before mem_ack was seen");
            end
            if (mem_req && !prev_req) begin
                ack_seen = 1'b0;   // new request
            end
            if (mem_req && mem_ack) begin
                ack_seen = 1'b1;
            end
            prev_req  = mem_req;
            prev_addr = mem_addr;
        end

        if (test_end) begin
            $display("test %-13s entries %4d  errors %0d",
                     test_name(test_id), test_entries, test_errors);
            test_entries = 0;
            test_errors  = 0;
        end
    end

endmodule

//--- verification/tb_ifu.sv
`timescale 1ns/100ps

module tb_ifu;
    import fetch_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int N_RESET      = 16;    // entries per test
    localparam int N_COLD       = 200;
    localparam int N_BP         = 200;
    localparam int N_REC        = 40;    // after each recovery pulse
    localparam int N_PULSES     = 4;
    localparam int REFILL_WORST = 20;    // cycles
    localparam int RUN_CYCLES   = (N_RESET + N_COLD + N_BP + N_REC * N_PULSES) * REFILL_WORST;

    localparam int RESP_IDLE  = 0;
    localparam int RESP_WAIT  = 1;
    localparam int RESP_ACKED = 2;

    logic         clk;
    logic         rst;
    logic [15:0]  recovery_pc;
    logic         recovery_pc_valid;
    logic         mem_req;
    logic [15:0]  mem_addr;
    logic         mem_ack;
    logic [63:0]  mem_data;
    logic         dispatch_ready;
    logic         instr_valid;
    logic [65:0]  instr_to_dispatch;

    fetch_entry_t dispatched;
    instr_t       image_word;
    instr_t       prog [65536];   // program image, one word per address
    logic [31:0]  lfsr;
    logic         rand_ready;     // random dispatch_ready when set
    int           resp_state;
    int           ack_wait;
    logic [2:0]   test_id;
    logic         test_end;
    int           entry_count;
    int           error_count;
    addr_t        rec_targets [N_PULSES] = '{16'h1234, 16'h8000, 16'hfff0, 16'h0040};

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};   // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic build_program();
        logic [31:0] sel;
        logic [31:0] back;
        logic [31:0] mag;
        logic [31:0] mid;
        logic [3:0]  op;
        addr_t       off;
        for (int a = 0; a < 65536; a++) begin
            take_bits(3, sel);
            take_bits(2, back);
            take_bits(8, mag);
            take_bits(12, mid);
            case (sel[2:0])
                3'd0, 3'd3: op = op_alu;
                3'd1:       op = op_load;
                3'd2:       op = 4'hb;   // unlisted code, alu behavior
                3'd4, 3'd5: op = op_br_cond;
                default:    op = op_jump;
            endcase
            if (back[1:0] == 2'b11) begin
                off = 16'hffff - {12'h0, mag[3:0]};   // short backward, -1 to -16
            end else begin
                off = {8'h0, mag[7:0]} + 16'd1;       // forward, +1 to +256
            end
            prog[a] = {op, mid[11:0], off};
        end
    endtask

    task automatic wait_entries(int n);
        int target;
        target = entry_count + n;
        while (entry_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic run_test(logic [2:0] id, int n);
        @(negedge clk);
        test_id = id;
        wait_entries(n);
        @(negedge clk);
        test_end = 1'b1;   // checker prints the test line
        @(negedge clk);
        test_end = 1'b0;
    endtask

    // dispatch back-pressure and memory responder
    always @(negedge clk) begin
        logic [31:0] bits;
        if (rand_ready) begin
            take_bits(1, bits);
            dispatch_ready = bits[0];
        end else begin
            dispatch_ready = 1'b1;
        end
        case (resp_state)
            RESP_IDLE: begin
                if (mem_req) begin
                    take_bits(3, bits);
                    ack_wait   = bits[2:0];   // 0 to 7 cycles
                    resp_state = RESP_WAIT;
                end
            end
            RESP_WAIT: begin
                if (ack_wait == 0) begin
                    mem_data   = {prog[{mem_addr[15:1], 1'b1}], prog[{mem_addr[15:1], 1'b0}]};
                    mem_ack    = 1'b1;
                    take_bits(2, bits);
                    ack_wait   = bits[1:0];   // ack held 0 to 3 cycles after req falls
                    resp_state = RESP_ACKED;
                end else begin
                    ack_wait--;
                end
            end
            default: begin
                if (!mem_req) begin
                    if (ack_wait == 0) begin
                        mem_ack    = 1'b0;   // phase 3
                        resp_state = RESP_IDLE;
                    end else begin
                        ack_wait--;
                    end
                end
            end
        endcase
    end

    assign dispatched = instr_to_dispatch;
    assign image_word = prog[dispatched.pc];

    ifu_top i_dut (
        .clk               (clk),
        .rst               (rst),
        .recovery_pc       (recovery_pc),
        .recovery_pc_valid (recovery_pc_valid),
        .mem_req           (mem_req),
        .mem_addr          (mem_addr),
        .mem_ack           (mem_ack),
        .mem_data          (mem_data),
        .dispatch_ready    (dispatch_ready),
        .instr_valid       (instr_valid),
        .instr_to_dispatch (instr_to_dispatch)
    );

    ifu_checker i_checker (
        .clk               (clk),
        .rst               (rst),
        .test_id           (test_id),
        .test_end          (test_end),
        .instr_valid       (instr_valid),
        .dispatch_ready    (dispatch_ready),
        .entry             (dispatched),
        .image_word        (image_word),
        .recovery_pc       (recovery_pc),
        .recovery_pc_valid (recovery_pc_valid),
        .mem_req           (mem_req),
        .mem_addr          (mem_addr),
        .mem_ack           (mem_ack),
        .entry_count       (entry_count),
        .error_count       (error_count)
    );

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        recovery_pc       = '0;
        recovery_pc_valid = 1'b0;
        mem_ack           = 1'b0;
        mem_data          = '0;
        dispatch_ready    = 1'b0;
        test_id           = '0;
        test_end          = 1'b0;
        rand_ready        = 1'b0;
        resp_state        = RESP_IDLE;
        ack_wait          = 0;
        lfsr              = 32'h8e496ef4;
        build_program();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_test(3'd1, N_RESET);
        run_test(3'd2, N_COLD);
        @(posedge clk);
        rand_ready = 1'b1;   // stays on for the rest of the run
        run_test(3'd3, N_BP);
        test_id = 3'd4;
        for (int p = 0; p < N_PULSES; p++) begin
            @(negedge clk);
            recovery_pc       = rec_targets[p];
            recovery_pc_valid = 1'b1;
            @(negedge clk);
            recovery_pc_valid = 1'b0;
            wait_entries(N_REC);
        end
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
        @(negedge clk);
        $display("4 tests, %0d entries checked, %0d errors", entry_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog, sized by entry counts times the worst refill time
    initial begin
        #((RUN_CYCLES + 10) * CLK_PERIOD);
        $display("watchdog: run did not complete within %0d cycles", RUN_CYCLES + 10);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- flist.f
source/fetch_pkg.sv
source/icache_pkg.sv
source/fetch_lookup_if.sv
source/pc_gen.sv
source/icache.sv
source/next_pc_predict.sv
source/instr_queue.sv
source/ifu_top.sv
verification/ifu_checker.sv
verification/tb_ifu.sv

//--- Bender.yml
package:
  name: ifu

sources:
  - source/fetch_pkg.sv
  - source/icache_pkg.sv
  - source/fetch_lookup_if.sv
  - source/pc_gen.sv
  - source/icache.sv
  - source/next_pc_predict.sv
  - source/instr_queue.sv
  - source/ifu_top.sv
  - target: test
    files:
      - verification/ifu_checker.sv
      - verification/tb_ifu.sv
